// File: verilog.f
logic/hwpf_pkg.sv
logic/hwpf_req_if.sv
logic/hwpf_stride_engine.sv
logic/hwpf_rr_arbiter.sv
logic/hwpf_stride_arb.sv
logic/hwpf_top.sv
test/hwpf_assert.sv
test/hwpf_tb.sv

// File: test/hwpf_tb.sv
// Stride prefetcher bank testbench
`timescale 1ns/1ns

module hwpf_tb;
    import hwpf_pkg::*;

    // Four engines at 255 lines with room for ready stalls
    localparam int CYCLE_LIMIT = 4000;

    logic                                      clk_i;
    logic                                      rst_n_i;
    logic [NUM_HW_PREFETCH-1:0]                start_i;
    logic [NUM_HW_PREFETCH-1:0][ADDR_W-1:0]    base_i;
    logic [NUM_HW_PREFETCH-1:0][STRIDE_W-1:0]  stride_i;
    logic [NUM_HW_PREFETCH-1:0][COUNT_W-1:0]   count_i;
    logic [NUM_HW_PREFETCH-1:0]                busy_o;
    logic [NUM_HW_PREFETCH-1:0]                done_o;
    logic                                      dc_req_valid_o;
    logic                                      dc_req_ready_i;
    logic [ADDR_W-1:0]                         dc_req_addr_o;
    logic [TID_W-1:0]                          dc_req_tid_o;
    logic                                      dc_rsp_valid_i;
    logic [TID_W-1:0]                          dc_rsp_tid_i;

    // Test knobs
    logic rand_ready;
    logic rand_delay;

    // Program for the next launch
    logic [ADDR_W-1:0]   cfg_base   [NUM_HW_PREFETCH];
    logic [STRIDE_W-1:0] cfg_stride [NUM_HW_PREFETCH];
    int                  cfg_count  [NUM_HW_PREFETCH];

    // Reference model of each engine
    logic                m_busy      [NUM_HW_PREFETCH];
    logic [ADDR_W-1:0]   m_base      [NUM_HW_PREFETCH];
    logic [STRIDE_W-1:0] m_stride    [NUM_HW_PREFETCH];
    int                  m_count     [NUM_HW_PREFETCH];
    int                  seen        [NUM_HW_PREFETCH];
    int                  outstanding [NUM_HW_PREFETCH];
    int                  done_cnt    [NUM_HW_PREFETCH];
    int                  m_ptr;
    int                  m_hold;

    // Cache responder queue
    int q_tid [$];
    int q_due [$];

    int          cycle;
    int          errors;
    int          checks;
    logic [31:0] rng_state;

    hwpf_top i_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .start_i        (start_i),
        .base_i         (base_i),
        .stride_i       (stride_i),
        .count_i        (count_i),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .dc_req_valid_o (dc_req_valid_o),
        .dc_req_ready_i (dc_req_ready_i),
        .dc_req_addr_o  (dc_req_addr_o),
        .dc_req_tid_o   (dc_req_tid_o),
        .dc_rsp_valid_i (dc_rsp_valid_i),
        .dc_rsp_tid_i   (dc_rsp_tid_i)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Line idx of a program, wrapping at ADDR_W
    function automatic logic [ADDR_W-1:0] exp_addr(input logic [ADDR_W-1:0] base,
                                                   input logic [STRIDE_W-1:0] stride,
                                                   input int idx);
        logic [63:0] full;
        full = 64'(base) + 64'(idx) * 64'(stride);
        return full[ADDR_W-1:0];
    endfunction

    // First requester at or after ptr, -1 when none
    function automatic int next_in_rotation(input logic [NUM_HW_PREFETCH-1:0] want,
                                            input int ptr);
        int idx;
        for (int off = 0; off < NUM_HW_PREFETCH; off++) begin
            idx = (ptr + off) % NUM_HW_PREFETCH;
            if (want[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic randomize_programs();
        logic [31:0] r;
        for (int g = 0; g < NUM_HW_PREFETCH; g++) begin
            r = next_random();
            cfg_base[g] = {r[31:6], 6'b0};
            r = next_random();
            cfg_stride[g] = r[STRIDE_W-1:0];
            cfg_count[g] = 1 + int'(next_random() % 24);
        end
    endtask

    // Program and pulse start on the engines in mask
    task automatic launch(input logic [NUM_HW_PREFETCH-1:0] mask);
        @(posedge clk_i);
        for (int g = 0; g < NUM_HW_PREFETCH; g++) begin
            if (mask[g]) begin
                base_i[g]   <= cfg_base[g];
                stride_i[g] <= cfg_stride[g];
                count_i[g]  <= COUNT_W'(cfg_count[g]);
            end
        end
        start_i <= mask;
        @(posedge clk_i);
        start_i <= '0;
    endtask

    // Watchdog cycle counter bounds this loop
    task automatic wait_done(input logic [NUM_HW_PREFETCH-1:0] mask);
        logic [NUM_HW_PREFETCH-1:0] pending;
        pending = mask;
        while (pending != '0) begin
            @(posedge clk_i);
            pending = pending & ~done_o;
        end
        @(posedge clk_i);
        for (int g = 0; g < NUM_HW_PREFETCH; g++) begin
            if (mask[g]) begin
                compare(busy_o[g], 1'b0, $sformatf("engine %0d busy after done", g));
                compare(seen[g], m_count[g], $sformatf("engine %0d transfer count", g));
            end
        end
    endtask

    // Ready at about three quarters when random
    always @(posedge clk_i) begin : ready_drive
        logic [31:0] r;
        r = next_random();
        dc_req_ready_i <= rand_ready ? (r[1:0] != 2'b00) : 1'b1;
    end

    // Returns the oldest due response, one per cycle
    always @(posedge clk_i) begin : responder
        int pick;
        int delay;
        pick = -1;
        for (int i = 0; i < q_due.size(); i++) begin
            if (q_due[i] <= cycle && (pick < 0 || q_due[i] < q_due[pick])) begin
                pick = i;
            end
        end
        if (pick >= 0) begin
            dc_rsp_valid_i <= 1'b1;
            dc_rsp_tid_i   <= TID_W'(q_tid[pick]);
            q_tid.delete(pick);
            q_due.delete(pick);
        end else begin
            dc_rsp_valid_i <= 1'b0;
        end
        if (rst_n_i && dc_req_valid_o && dc_req_ready_i) begin
            delay = rand_delay ? 1 + int'(next_random() % 6) : 1;
            q_tid.push_back(int'(dc_req_tid_o));
            q_due.push_back(cycle + delay);
        end
    end

    // Compares every cycle against the engine and arbiter rules
    always @(posedge clk_i) begin : scoreboard
        logic [NUM_HW_PREFETCH-1:0] want;
        logic [NUM_HW_PREFETCH-1:0] exp_done;
        int tid;
        int exp_tid;
        if (!rst_n_i) begin
            m_ptr  = 0;
            m_hold = -1;
            for (int g = 0; g < NUM_HW_PREFETCH; g++) begin
                m_busy[g]      = 1'b0;
                m_count[g]     = 0;
                seen[g]        = 0;
                outstanding[g] = 0;
                done_cnt[g]    = 0;
            end
        end else begin
            // Status from values before this edge
            for (int g = 0; g < NUM_HW_PREFETCH; g++) begin
                want[g] = m_busy[g] && (seen[g] < m_count[g])
                          && (outstanding[g] < MAX_INFLIGHT);
                exp_done[g] = m_busy[g] && (seen[g] >= m_count[g]) && (outstanding[g] == 0);
                compare(busy_o[g], m_busy[g], $sformatf("engine %0d busy", g));
                compare(done_o[g], exp_done[g], $sformatf("engine %0d done", g));
            end
            compare(dc_req_valid_o, |want, "request valid");
            // Stalled winner keeps the port, otherwise next in rotation
            exp_tid = (m_hold >= 0) ? m_hold : next_in_rotation(want, m_ptr);
            if (dc_rsp_valid_i) begin
                compare(outstanding[dc_rsp_tid_i] > 0, 1'b1, "response with nothing in flight");
                outstanding[dc_rsp_tid_i]--;
            end
            // Presented request checked every cycle, so a stall must hold it
            if (dc_req_valid_o && exp_tid >= 0) begin
                compare(dc_req_tid_o, exp_tid, "round-robin tid");
                compare(dc_req_addr_o, exp_addr(m_base[exp_tid], m_stride[exp_tid],
                                                seen[exp_tid]),
                        $sformatf("engine %0d address %0d", exp_tid, seen[exp_tid]));
            end
            if (dc_req_valid_o && dc_req_ready_i) begin
                tid = int'(dc_req_tid_o);
                seen[tid]++;
                outstanding[tid]++;
                compare(outstanding[tid] <= MAX_INFLIGHT, 1'b1,
                        $sformatf("engine %0d in-flight limit", tid));
                m_ptr = (tid + 1) % NUM_HW_PREFETCH;
            end
            m_hold = (exp_tid >= 0 && !dc_req_ready_i) ? exp_tid : -1;
            // Done pulses counted at the port, retire and start from the model
            for (int g = 0; g < NUM_HW_PREFETCH; g++) begin
                if (done_o[g]) begin
                    done_cnt[g]++;
                end
                if (exp_done[g]) begin
                    m_busy[g] = 1'b0;
                end else if (!m_busy[g] && start_i[g]) begin
                    m_busy[g]   = 1'b1;
                    m_base[g]   = base_i[g];
                    m_stride[g] = stride_i[g];
                    m_count[g]  = int'(count_i[g]);
                    seen[g]     = 0;
                end
            end
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin : stimulus
        int zero_done;
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        start_i        = '0;
        base_i         = '0;
        stride_i       = '0;
        count_i        = '0;
        dc_req_ready_i = 1'b1;
        dc_rsp_valid_i = 1'b0;
        dc_rsp_tid_i   = '0;
        rand_ready     = 1'b0;
        rand_delay     = 1'b0;
        rng_state      = 32'd68681;
        cycle          = 0;
        errors         = 0;
        checks         = 0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Single engine, ready high
        cfg_base[0]   = 32'h1000_0000;
        cfg_stride[0] = 16'd64;
        cfg_count[0]  = 12;
        launch(4'b0001);
        wait_done(4'b0001);

        // All four from one start
        randomize_programs();
        launch(4'b1111);
        wait_done(4'b1111);

        // Equal long programs keep every engine asking, rotation checked per transfer
        for (int g = 0; g < NUM_HW_PREFETCH; g++) begin
            cfg_base[g]   = 32'h2000_0000 + (g << 12);
            cfg_stride[g] = 16'd32;
            cfg_count[g]  = 16;
        end
        launch(4'b1111);
        wait_done(4'b1111);

        // Random back-pressure
        rand_ready <= 1'b1;
        randomize_programs();
        launch(4'b1111);
        wait_done(4'b1111);

        // Out of order responses, then with stalls too
        rand_ready <= 1'b0;
        rand_delay <= 1'b1;
        randomize_programs();
        launch(4'b1111);
        wait_done(4'b1111);
        rand_ready <= 1'b1;
        randomize_programs();
        launch(4'b1111);
        wait_done(4'b1111);

        // Count zero on engine 1, restart attempt on busy engine 2
        rand_ready <= 1'b0;
        rand_delay <= 1'b0;
        cfg_count[1]  = 0;
        cfg_base[2]   = 32'h3000_0100;
        cfg_stride[2] = 16'd8;
        cfg_count[2]  = 20;
        zero_done = done_cnt[1];
        launch(4'b0110);
        repeat (4) @(posedge clk_i);
        cfg_base[2]  = 32'h7000_0000;
        cfg_count[2] = 5;
        launch(4'b0100);
        wait_done(4'b0100);
        compare(done_cnt[1], zero_done + 1, "count zero done pulse");
        compare(seen[1], 0, "count zero issued a request");
        compare(seen[2], 20, "restart while busy was taken");

        repeat (4) @(posedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: test/hwpf_assert.sv
// Arbiter handshake assertions
`timescale 1ns/1ns

module hwpf_arb_assert (
    input  logic                                                      clk_i,
    input  logic                                                      rst_n_i,
    input  logic [hwpf_pkg::NUM_HW_PREFETCH-1:0]                      arb_gnt_i,
    input  logic [hwpf_pkg::NUM_HW_PREFETCH-1:0]                      req_valid_i,
    input  logic [hwpf_pkg::NUM_HW_PREFETCH-1:0][hwpf_pkg::ADDR_W-1:0] req_addr_i,
    input  logic                                                      dc_req_valid_i,
    input  logic                                                      dc_req_ready_i,
    input  logic [hwpf_pkg::ADDR_W-1:0]                               dc_req_addr_i,
    input  logic [hwpf_pkg::TID_W-1:0]                                dc_req_tid_i,
    input  logic                                                      dc_rsp_valid_i,
    input  logic [hwpf_pkg::TID_W-1:0]                                dc_rsp_tid_i
);
    import hwpf_pkg::*;

    // Outstanding requests per tid as seen at the cache port
    logic [2:0] pending_q [NUM_HW_PREFETCH];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_HW_PREFETCH; i++) begin
                pending_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_HW_PREFETCH; i++) begin
                pending_q[i] <= pending_q[i]
                    + 3'(dc_req_valid_i && dc_req_ready_i && (dc_req_tid_i == TID_W'(i)))
                    - 3'(dc_rsp_valid_i && (dc_rsp_tid_i == TID_W'(i)));
            end
        end
    end

    // At most one engine granted
    gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(arb_gnt_i))
        else $error("grant vector is not one-hot or zero");

    // Stalled port keeps the same request presented
    port_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dc_req_valid_i && !dc_req_ready_i
        |=> dc_req_valid_i && $stable(dc_req_addr_i) && $stable(dc_req_tid_i))
        else $error("request valid, address or tid changed while stalled");

    for (genvar g = 0; g < NUM_HW_PREFETCH; g++) begin : gen_engine_chk
        // Per engine, so the index held here is also the tid
        req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            req_valid_i[g] && !(arb_gnt_i[g] && dc_req_ready_i)
            |=> req_valid_i[g] && $stable(req_addr_i[g]))
            else $error("engine %0d changed a stalled request", g);

        // A response needs a request behind it
        rsp_has_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            dc_rsp_valid_i && (dc_rsp_tid_i == TID_W'(g)) |-> pending_q[g] != '0)
            else $error("response for engine %0d with nothing in flight", g);

        credit_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            pending_q[g] <= 3'(MAX_INFLIGHT))
            else $error("engine %0d exceeds its in-flight limit", g);
    end

endmodule

bind hwpf_stride_arb hwpf_arb_assert u_arb_assert (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .arb_gnt_i      (arb_gnt),
    .req_valid_i    (req_valid),
    .req_addr_i     (req_addr),
    .dc_req_valid_i (dc_req_valid_o),
    .dc_req_ready_i (dc_req_ready_i),
    .dc_req_addr_i  (dc_req_addr_o),
    .dc_req_tid_i   (dc_req_tid_o),
    .dc_rsp_valid_i (dc_rsp_valid_i),
    .dc_rsp_tid_i   (dc_rsp_tid_i)
);

// File: logic/hwpf_top.sv
// Stride prefetcher bank top level
`timescale 1ns/1ns

module hwpf_top (
    input  logic                                                       clk_i,
    input  logic                                                       rst_n_i,

    // Engine programs
    input  logic [hwpf_pkg::NUM_HW_PREFETCH-1:0]                       start_i,
    input  logic [hwpf_pkg::NUM_HW_PREFETCH-1:0][hwpf_pkg::ADDR_W-1:0]   base_i,
    input  logic [hwpf_pkg::NUM_HW_PREFETCH-1:0][hwpf_pkg::STRIDE_W-1:0] stride_i,
    input  logic [hwpf_pkg::NUM_HW_PREFETCH-1:0][hwpf_pkg::COUNT_W-1:0]  count_i,

    // Engine status
    output logic [hwpf_pkg::NUM_HW_PREFETCH-1:0]                       busy_o,
    output logic [hwpf_pkg::NUM_HW_PREFETCH-1:0]                       done_o,

    // Data cache request port
    output logic                                                       dc_req_valid_o,
    input  logic                                                       dc_req_ready_i,
    output logic [hwpf_pkg::ADDR_W-1:0]                                dc_req_addr_o,
    output logic [hwpf_pkg::TID_W-1:0]                                 dc_req_tid_o,

    // Data cache response strobe
    input  logic                                                       dc_rsp_valid_i,
    input  logic [hwpf_pkg::TID_W-1:0]                                 dc_rsp_tid_i
);
    import hwpf_pkg::*;

    // One link per engine
    hwpf_req_if pf_if [NUM_HW_PREFETCH] ();

    // Engines side by side
    for (genvar g = 0; g < NUM_HW_PREFETCH; g++) begin : gen_engine
        hwpf_stride_engine u_engine (
            .clk_i    (clk_i),
            .rst_n_i  (rst_n_i),
            .start_i  (start_i[g]),
            .base_i   (base_i[g]),
            .stride_i (stride_i[g]),
            .count_i  (count_i[g]),
            .req      (pf_if[g]),
            .busy_o   (busy_o[g]),
            .done_o   (done_o[g])
        );
    end

    // Shared cache port
    hwpf_stride_arb u_arb (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .pf             (pf_if),
        .dc_req_valid_o (dc_req_valid_o),
        .dc_req_ready_i (dc_req_ready_i),
        .dc_req_addr_o  (dc_req_addr_o),
        .dc_req_tid_o   (dc_req_tid_o),
        .dc_rsp_valid_i (dc_rsp_valid_i),
        .dc_rsp_tid_i   (dc_rsp_tid_i)
    );

endmodule

// File: logic/hwpf_stride_arb.sv
// Prefetch request arbiter
`timescale 1ns/1ns

module hwpf_stride_arb (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    hwpf_req_if.arbiter                  pf [hwpf_pkg::NUM_HW_PREFETCH],
    output logic                         dc_req_valid_o,
    input  logic                         dc_req_ready_i,
    output logic [hwpf_pkg::ADDR_W-1:0]  dc_req_addr_o,
    output logic [hwpf_pkg::TID_W-1:0]   dc_req_tid_o,
    input  logic                         dc_rsp_valid_i,
    input  logic [hwpf_pkg::TID_W-1:0]   dc_rsp_tid_i
);
    import hwpf_pkg::*;

    // Flattened engine requests
    logic [NUM_HW_PREFETCH-1:0]             req_valid;
    logic [NUM_HW_PREFETCH-1:0][ADDR_W-1:0] req_addr;

    // One-hot grant, zero when nobody asks
    logic [NUM_HW_PREFETCH-1:0]             arb_gnt;

    // Per-engine wiring
    for (genvar g = 0; g < NUM_HW_PREFETCH; g++) begin : gen_port
        assign req_valid[g] = pf[g].req_valid;
        assign req_addr[g]  = pf[g].req_addr;

        // Granted engine sees ready straight from the cache
        assign pf[g].req_ready = arb_gnt[g] & dc_req_ready_i;

        // Response demux on the returned id
        assign pf[g].rsp_valid = dc_rsp_valid_i && (dc_rsp_tid_i == TID_W'(g));
    end

    hwpf_rr_arbiter u_rr_arbiter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_valid),
        .ready_i (dc_req_ready_i),
        .gnt_o   (arb_gnt)
    );

    // AND-OR mux on the one-hot grant, index doubles as tid
    always_comb begin : req_mux
        dc_req_addr_o = '0;
        dc_req_tid_o  = '0;
        for (int unsigned i = 0; i < NUM_HW_PREFETCH; i++) begin
            dc_req_addr_o = dc_req_addr_o | (req_addr[i] & {ADDR_W{arb_gnt[i]}});
            if (arb_gnt[i]) begin
                dc_req_tid_o = TID_W'(i);
            end
        end
    end

    // Any grant means a request is presented
    assign dc_req_valid_o = |arb_gnt;

endmodule

// File: logic/hwpf_rr_arbiter.sv
// Round-robin grant unit
`timescale 1ns/1ns

module hwpf_rr_arbiter (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [hwpf_pkg::NUM_HW_PREFETCH-1:0] req_i,
    input  logic                                ready_i,
    output logic [hwpf_pkg::NUM_HW_PREFETCH-1:0] gnt_o
);
    import hwpf_pkg::*;

    // Highest priority requester this cycle
    logic [TID_W-1:0] ptr_q;

    // Stalled winner keeps the grant until it transfers
    logic             hold_q;
    logic [TID_W-1:0] hold_idx_q;
    logic [TID_W-1:0] search_idx;

    // Winner of the current search
    logic [TID_W-1:0] win_idx;
    logic             found;

    // Held winner still requests, so searching from it keeps it granted
    assign search_idx = hold_q ? hold_idx_q : ptr_q;

    // First requester at or after the search start
    always_comb begin : pick
        int unsigned idx;

        gnt_o   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int unsigned off = 0; off < NUM_HW_PREFETCH; off++) begin
            idx = (search_idx + off) % NUM_HW_PREFETCH;
            if (!found && req_i[idx]) begin
                found        = 1'b1;
                gnt_o[idx]   = 1'b1;
                win_idx      = TID_W'(idx);
            end
        end
    end

    // Rotate past the winner, only on an actual transfer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q      <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            // Lock only while a presented request is stalled
            hold_q     <= found && !ready_i;
            hold_idx_q <= win_idx;
            if (ready_i && found) begin
                if (win_idx == TID_W'(NUM_HW_PREFETCH - 1)) begin
                    ptr_q <= '0;
                end else begin
                    ptr_q <= win_idx + TID_W'(1);
                end
            end
        end
    end

endmodule

// File: logic/hwpf_stride_engine.sv
// Programmable stride prefetch engine
`timescale 1ns/1ns

module hwpf_stride_engine (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          start_i,
    input  logic [hwpf_pkg::ADDR_W-1:0]   base_i,
    input  logic [hwpf_pkg::STRIDE_W-1:0] stride_i,
    input  logic [hwpf_pkg::COUNT_W-1:0]  count_i,
    hwpf_req_if.engine                    req,
    output logic                          busy_o,
    output logic                          done_o
);
    import hwpf_pkg::*;

    // FSM
    hwpf_state_e         state_q;
    hwpf_state_e         state_d;

    // Program and walk state
    logic [ADDR_W-1:0]   addr_q;
    logic [STRIDE_W-1:0] stride_q;
    logic [COUNT_W-1:0]  remaining_q;
    logic [INFL_W-1:0]   inflight_q;

    // Events
    logic                accept_start;
    logic                has_credit;
    logic                fire;
    logic                last_req;

    // New program only taken in IDLE
    assign accept_start = (state_q == IDLE) && start_i;

    // Credit left for another request
    assign has_credit = inflight_q < INFL_W'(MAX_INFLIGHT);

    // Valid can only drop through a transfer, so it holds under stall
    assign req.req_valid = (state_q == ISSUE) && (remaining_q != '0) && has_credit;
    assign req.req_addr  = addr_q;

    assign fire     = req.req_valid && req.req_ready;
    assign last_req = fire && (remaining_q == COUNT_W'(1));

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // Zero count skips issuing entirely
                if (start_i) begin
                    state_d = (count_i == '0) ? DRAIN : ISSUE;
                end
            end
            ISSUE: begin
                if (last_req) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                // Back to idle once every response is in
                if (inflight_q == '0) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Control state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            remaining_q <= '0;
            inflight_q  <= '0;
        end else begin
            state_q <= state_d;

            // Lines still to request
            if (accept_start) begin
                remaining_q <= count_i;
            end else if (fire) begin
                remaining_q <= remaining_q - COUNT_W'(1);
            end

            // Up on transfer, down on response, both may hit in one cycle
            inflight_q <= inflight_q + INFL_W'(fire) - INFL_W'(req.rsp_valid);
        end
    end

    // Address walk
    always_ff @(posedge clk_i) begin
        if (accept_start) begin
            addr_q   <= base_i;
            stride_q <= stride_i;
        end else if (fire) begin
            // Stride zero-extended, wraps at ADDR_W
            addr_q <= addr_q + {{(ADDR_W - STRIDE_W){1'b0}}, stride_q};
        end
    end

    // Status
    assign busy_o = (state_q != IDLE);

    // Single cycle, the one after the last response
    assign done_o = (state_q == DRAIN) && (inflight_q == '0);

endmodule

// File: logic/hwpf_req_if.sv
// Engine to arbiter request link
`timescale 1ns/1ns

interface hwpf_req_if;
    import hwpf_pkg::*;

    // Request side, held stable until req_ready
    logic              req_valid;
    logic              req_ready;
    logic [ADDR_W-1:0] req_addr;

    // One-cycle strobe per returned response
    logic              rsp_valid;

    // Prefetcher end
    modport engine (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  rsp_valid
    );

    // Arbiter end
    modport arbiter (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid
    );

endinterface

// File: logic/hwpf_pkg.sv
// Stride prefetcher shared definitions
package hwpf_pkg;

    // Number of stride engines sharing the cache port
    localparam int NUM_HW_PREFETCH = 4;

    // Transaction id carries the engine index
    localparam int TID_W = $clog2(NUM_HW_PREFETCH);

    // Prefetch address width
    localparam int ADDR_W = 32;

    // Unsigned byte offset between lines
    localparam int STRIDE_W = 16;

    // Lines per program, up to 255
    localparam int COUNT_W = 8;

    // Outstanding requests allowed per engine
    localparam int MAX_INFLIGHT = 2;

    // Enough bits to hold 0..MAX_INFLIGHT
    localparam int INFL_W = 2;

    // Engine FSM
    //   IDLE  waiting for start
    //   ISSUE walking the address, requests still to send
    //   DRAIN all sent, waiting on responses
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } hwpf_state_e;

endpackage
